//--- sim.f
hw/rvExecPkg.sv
hw/aluUnit.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/rvExecTop.sv
test/rvExec_checker.sv
test/rvExecTb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - hw/rvExecPkg.sv
  - hw/aluUnit.sv
  - hw/regFile.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/rvExecTop.sv
  - target: test
    files:
      - test/rvExec_checker.sv
      - test/rvExecTb.sv

//--- test/rvExecTb.sv
`timescale 1ns/1ps

module rvExecTb;

	localparam int TimeoutCycles = 400; // about twice the issue and drain cycles of all tests

	typedef struct packed
	{
		logic [31:0]       due; // cycle count at which the outputs are checked
		logic              expCommit;
		rvExecPkg::commitT commit;
		logic              expRedirect;
		rvExecPkg::dataT   target;
		logic              expIllegal;
	} expectT;

	logic              clk;
	logic              reset;
	logic              instrValid;
	rvExecPkg::instrT  instr;
	logic              commitValid;
	rvExecPkg::commitT commit;
	logic              pcWriteEnable;
	rvExecPkg::dataT   pcWriteData;
	logic              illegal;

	rvExecPkg::dataT model [0:31]; // architectural register state
	expectT          expQ [$];
	string           nameQ [$];
	expectT          cur;
	string           curName;
	rvExecPkg::dataT pcNext;
	int              cycle;
	int              mismatchCount;
	int              strobeErrors;
	integer          seed;

	rvExecTop u_dut
	(
		.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
		.commitValid(commitValid), .commit(commit),
		.pcWriteEnable(pcWriteEnable), .pcWriteData(pcWriteData), .illegal(illegal)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle == TimeoutCycles)
		begin
			$display("timeout after %0d cycles, %0d results still pending", cycle, expQ.size());
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic rvExecPkg::dataT aluRef(logic [2:0] f3, logic alt, rvExecPkg::dataT a,
		rvExecPkg::dataT b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? rvExecPkg::dataT'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTaken(logic [2:0] f3, rvExecPkg::dataT a, rvExecPkg::dataT b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// ISA model, also retires the instruction into the model registers
	function automatic expectT predict(rvExecPkg::instrT ins);
		expectT          e;
		rvExecPkg::dataT a;
		rvExecPkg::dataT b;
		rvExecPkg::dataT v;
		logic            writes;
		logic            alt;
		e = '0;
		e.due = cycle + 2;
		a = model[ins.regNum0];
		b = (ins.opcode == rvExecPkg::OpImm) ? ins.imm : model[ins.regNum1];
		v = '0;
		writes = 1'b0;
		case (ins.opcode)
			rvExecPkg::OpReg, rvExecPkg::OpImm:
			begin
				alt = (ins.opcode == rvExecPkg::OpReg) ? ins.func7[5] :
					(ins.func3 == 3'd5) && ins.imm[10]; // srai only
				v = aluRef(ins.func3, alt, a, b);
				writes = 1'b1;
			end
			rvExecPkg::OpBranch:
			begin
				e.expIllegal = (ins.func3 == 3'd2) || (ins.func3 == 3'd3);
				e.expRedirect = !e.expIllegal && branchTaken(ins.func3, a, b);
				e.target = ins.pc + ins.imm;
			end
			rvExecPkg::OpJal, rvExecPkg::OpJalr:
			begin
				v = ins.pc + 32'd4; // link
				writes = 1'b1;
				e.expRedirect = 1'b1;
				e.target = (ins.opcode == rvExecPkg::OpJal) ? ins.pc + ins.imm :
					(a + ins.imm) & ~32'd1;
			end
			rvExecPkg::OpLui:
			begin
				v = ins.imm;
				writes = 1'b1;
			end
			rvExecPkg::OpAuipc:
			begin
				v = ins.pc + ins.imm;
				writes = 1'b1;
			end
			default: e.expIllegal = 1'b1; // loads, stores, unknown
		endcase
		if (writes && (ins.regWriteNum != '0))
		begin
			e.expCommit = 1'b1;
			e.commit = '{regNum: ins.regWriteNum, data: v};
			model[ins.regWriteNum] = v;
		end
		return e;
	endfunction

	function automatic rvExecPkg::instrT mk(rvExecPkg::opcodeT opc, logic [2:0] f3, logic [6:0] f7,
		rvExecPkg::regNumT rd, rvExecPkg::regNumT rs1, rvExecPkg::regNumT rs2, rvExecPkg::dataT imm);
		rvExecPkg::instrT ins;
		ins.opcode = opc;
		ins.func3 = f3;
		ins.func7 = f7;
		ins.regWriteNum = rd;
		ins.regNum0 = rs1;
		ins.regNum1 = rs2;
		ins.imm = imm;
		ins.pc = pcNext;
		return ins;
	endfunction

	task automatic checkCommit(input string testName, input rvExecPkg::commitT expected,
		input rvExecPkg::commitT actual);
		if (actual !== expected)
		begin
			mismatchCount++;
			$display("mismatch %s commit: expected x%0d=%h, actual x%0d=%h", testName,
				expected.regNum, expected.data, actual.regNum, actual.data);
		end
	endtask

	task automatic checkRedirect(input string testName, input rvExecPkg::dataT expected,
		input rvExecPkg::dataT actual);
		if (actual !== expected)
		begin
			mismatchCount++;
			$display("mismatch %s redirect: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic checkIllegal(input string testName, input bit expected, input bit actual);
		if (actual !== expected)
		begin
			mismatchCount++;
			$display("mismatch %s illegal: expected %0b, actual %0b", testName, expected, actual);
		end
	endtask

	task automatic compareOutputs(input string testName, input expectT e);
		if (e.expCommit != commitValid)
		begin
			strobeErrors++;
			$display("%s: commit strobe was %0b where %0b was due", testName, commitValid,
				e.expCommit);
		end
		else if (e.expCommit)
			checkCommit(testName, e.commit, commit);
		if (e.expRedirect != pcWriteEnable)
		begin
			strobeErrors++;
			$display("%s: redirect strobe was %0b where %0b was due", testName, pcWriteEnable,
				e.expRedirect);
		end
		else if (e.expRedirect)
			checkRedirect(testName, e.target, pcWriteData);
		checkIllegal(testName, e.expIllegal, illegal);
	endtask

	// outputs change only on the rising edge, so check them half a cycle later
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if ((expQ.size() != 0) && (expQ[0].due == cycle))
			begin
				cur = expQ.pop_front();
				curName = nameQ.pop_front();
				compareOutputs(curName, cur);
			end
			else if (commitValid || pcWriteEnable || illegal)
			begin
				strobeErrors++;
				$display("output strobe raised at cycle %0d with no instruction due", cycle);
			end
		end
	end

	task automatic issue(input string testName, input rvExecPkg::instrT ins);
		@(negedge clk);
		instr = ins;
		instrValid = 1'b1;
		expQ.push_back(predict(ins));
		nameQ.push_back(testName);
		pcNext = pcNext + 32'd4;
	endtask

	task automatic drain();
		@(negedge clk);
		instrValid = 1'b0;
		instr = '0;
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic testRType();
		issue("rtype", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd1, 5'd0, 5'd0, -32'd25));
		issue("rtype", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd2, 5'd0, 5'd0, 32'd7));
		issue("rtype", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd3, 5'd0, 5'd0, -32'd1024));
		for (int f = 0; f < 8; f++)
			issue("rtype", mk(rvExecPkg::OpReg, 3'(f), 7'd0, 5'(10 + f), 5'd3, 5'd2, '0));
		issue("rtype", mk(rvExecPkg::OpReg, 3'd0, 7'h20, 5'd18, 5'd1, 5'd2, '0)); // sub
		issue("rtype", mk(rvExecPkg::OpReg, 3'd5, 7'h20, 5'd19, 5'd3, 5'd2, '0)); // sra
		drain();
	endtask

	task automatic testIType();
		issue("itype", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd4, 5'd0, 5'd0, -32'd200));
		issue("itype", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd5, 5'd4, 5'd0, 32'd77));
		issue("itype", mk(rvExecPkg::OpImm, 3'd2, 7'd0, 5'd6, 5'd4, 5'd0, -32'd199));
		issue("itype", mk(rvExecPkg::OpImm, 3'd3, 7'd0, 5'd7, 5'd4, 5'd0, 32'd5));
		issue("itype", mk(rvExecPkg::OpImm, 3'd4, 7'd0, 5'd8, 5'd4, 5'd0, -32'd1));
		issue("itype", mk(rvExecPkg::OpImm, 3'd6, 7'd0, 5'd9, 5'd4, 5'd0, 32'h0f0));
		issue("itype", mk(rvExecPkg::OpImm, 3'd7, 7'd0, 5'd20, 5'd4, 5'd0, 32'h7ff));
		issue("itype", mk(rvExecPkg::OpImm, 3'd1, 7'd0, 5'd21, 5'd4, 5'd0, 32'd3));
		issue("itype", mk(rvExecPkg::OpImm, 3'd5, 7'd0, 5'd22, 5'd4, 5'd0, 32'd4));
		issue("itype", mk(rvExecPkg::OpImm, 3'd5, 7'd0, 5'd23, 5'd4, 5'd0, 32'h404)); // srai
		issue("itype", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd0, 5'd4, 5'd0, 32'd5)); // to x0
		issue("itype", mk(rvExecPkg::OpReg, 3'd0, 7'd0, 5'd24, 5'd0, 5'd4, '0));
		drain();
	endtask

	task automatic testBypass();
		issue("bypass", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd25, 5'd0, 5'd0, 32'd3));
		issue("bypass", mk(rvExecPkg::OpReg, 3'd0, 7'd0, 5'd26, 5'd25, 5'd25, '0));
		issue("bypass", mk(rvExecPkg::OpReg, 3'd0, 7'h20, 5'd27, 5'd26, 5'd25, '0));
		issue("bypass", mk(rvExecPkg::OpReg, 3'd4, 7'd0, 5'd28, 5'd27, 5'd26, '0));
		issue("bypass", mk(rvExecPkg::OpImm, 3'd1, 7'd0, 5'd29, 5'd28, 5'd0, 32'd2));
		issue("bypass", mk(rvExecPkg::OpReg, 3'd0, 7'd0, 5'd30, 5'd29, 5'd28, '0));
		issue("bypass", mk(rvExecPkg::OpImm, 3'd5, 7'd0, 5'd31, 5'd30, 5'd0, 32'h401));
		drain();
	endtask

	task automatic testBranches();
		logic [2:0] codes [6];
		codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		issue("branch", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd1, 5'd0, 5'd0, 32'd5));
		issue("branch", mk(rvExecPkg::OpImm, 3'd0, 7'd0, 5'd2, 5'd0, 5'd0, -32'd3));
		for (int i = 0; i < 6; i++)
		begin
			issue("branch", mk(rvExecPkg::OpBranch, codes[i], 7'd0, 5'd0, 5'd1, 5'd1, 32'd16));
			issue("branch", mk(rvExecPkg::OpBranch, codes[i], 7'd0, 5'd0, 5'd1, 5'd2, -32'd8));
			issue("branch", mk(rvExecPkg::OpBranch, codes[i], 7'd0, 5'd0, 5'd2, 5'd1, 32'd24));
		end
		issue("jump", mk(rvExecPkg::OpJal, 3'd0, 7'd0, 5'd3, 5'd0, 5'd0, 32'h40));
		issue("jump", mk(rvExecPkg::OpJalr, 3'd0, 7'd0, 5'd4, 5'd1, 5'd0, 32'd6));
		issue("jump", mk(rvExecPkg::OpJalr, 3'd0, 7'd0, 5'd5, 5'd2, 5'd0, 32'd8)); // odd sum
		drain();
	endtask

	task automatic testUpper();
		issue("upper", mk(rvExecPkg::OpLui, 3'd0, 7'd0, 5'd6, 5'd0, 5'd0, 32'h12345000));
		issue("upper", mk(rvExecPkg::OpAuipc, 3'd0, 7'd0, 5'd7, 5'd0, 5'd0, 32'h2000));
		issue("illegal", mk(rvExecPkg::OpLoad, 3'd2, 7'd0, 5'd6, 5'd1, 5'd0, 32'd4));
		issue("illegal", mk(rvExecPkg::OpStore, 3'd2, 7'd0, 5'd6, 5'd1, 5'd2, 32'd8));
		issue("illegal", mk(rvExecPkg::opcodeT'(7'h7f), 3'd0, 7'd0, 5'd6, 5'd1, 5'd2, 32'd1));
		issue("illegal", mk(rvExecPkg::OpReg, 3'd0, 7'd0, 5'd8, 5'd6, 5'd7, '0)); // x6 intact
		drain();
	endtask

	task automatic testRandom();
		logic [31:0]       r;
		rvExecPkg::opcodeT opc;
		logic [2:0]        f3;
		logic [6:0]        f7;
		for (int i = 0; i < 60; i++)
		begin
			r = $random(seed);
			opc = r[0] ? rvExecPkg::OpReg : rvExecPkg::OpImm;
			f3 = r[3:1];
			f7 = (r[4] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'd0;
			issue("random", mk(opc, f3, f7, r[9:5], r[14:10], r[19:15], {{20{r[31]}}, r[31:20]}));
		end
		drain();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pcNext = 32'h100;
		cycle = 0;
		mismatchCount = 0;
		strobeErrors = 0;
		seed = 32'h6e78;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		testRType();
		testIType();
		testBypass();
		testBranches();
		testUpper();
		testRandom();
		repeat (2) @(negedge clk);
		$display("errors: %0d value mismatches, %0d strobe errors", mismatchCount, strobeErrors);
		if ((mismatchCount == 0) && (strobeErrors == 0))
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- test/rvExec_checker.sv
`timescale 1ns/1ps

module rvExecChecker
(
	input logic              clk,
	input logic              reset,
	input logic              instrValid,
	input logic              commitValid,
	input rvExecPkg::commitT commit,
	input logic              pcWriteEnable,
	input logic              illegal
);

	// decode takes the instruction one edge before the outputs are registered
	commitHasIssue: assert property (@(posedge clk) disable iff (reset)
		commitValid |-> $past(instrValid, 2))
		else $error("commit with no instruction issued two edges before");

	commitNotIllegal: assert property (@(posedge clk) disable iff (reset)
		!(commitValid && illegal))
		else $error("commit and illegal high together");

	redirectNotIllegal: assert property (@(posedge clk) disable iff (reset)
		!(pcWriteEnable && illegal))
		else $error("redirect and illegal high together");

	commitNotX0: assert property (@(posedge clk) disable iff (reset)
		commitValid |-> (commit.regNum != '0))
		else $error("commit to register 0");

	quietAfterReset: assert property (@(posedge clk)
		reset |=> !(commitValid || pcWriteEnable || illegal))
		else $error("output strobe high right after reset");

endmodule

bind rvExecTop rvExecChecker protocolCheck (.*);

//--- hw/rvExecTop.sv
`timescale 1ns/1ps

module rvExecTop
(
	input  logic              clk,
	input  logic              reset,
	input  logic              instrValid,
	input  rvExecPkg::instrT  instr,
	output logic              commitValid,
	output rvExecPkg::commitT commit,
	output logic              pcWriteEnable,
	output rvExecPkg::dataT   pcWriteData,
	output logic              illegal
);

	logic                 opValid;
	rvExecPkg::decodedOpT op;
	rvExecPkg::aluOpT     aluOp;
	rvExecPkg::dataT      aluX;
	rvExecPkg::dataT      aluY;
	rvExecPkg::dataT      aluO;
	logic                 writeEnable; // shared by regfile and bypass
	rvExecPkg::regNumT    writeNum;
	rvExecPkg::dataT      writeData;
	rvExecPkg::regNumT    readNum0;
	rvExecPkg::regNumT    readNum1;
	rvExecPkg::dataT      readData0;
	rvExecPkg::dataT      readData1;

	decodeStage decode
	(
		.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
		.readNum0(readNum0), .readNum1(readNum1),
		.readData0(readData0), .readData1(readData1),
		.writeEnable(writeEnable), .writeNum(writeNum), .writeData(writeData),
		.opValid(opValid), .op(op)
	);

	executeStage execute
	(
		.clk(clk), .reset(reset), .opValid(opValid), .op(op),
		.aluOp(aluOp), .aluX(aluX), .aluY(aluY), .aluO(aluO),
		.writeEnable(writeEnable), .writeNum(writeNum), .writeData(writeData),
		.commitValid(commitValid), .commit(commit),
		.pcWriteEnable(pcWriteEnable), .pcWriteData(pcWriteData), .illegal(illegal)
	);

	aluUnit alu
	(
		.aluOp(aluOp), .aluX(aluX), .aluY(aluY), .aluO(aluO)
	);

	regFile rf
	(
		.clk(clk), .reset(reset),
		.readNum0(readNum0), .readNum1(readNum1),
		.readData0(readData0), .readData1(readData1),
		.writeEnable(writeEnable), .writeNum(writeNum), .writeData(writeData)
	);

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 opValid,
	input  rvExecPkg::decodedOpT op,
	output rvExecPkg::aluOpT     aluOp,
	output rvExecPkg::dataT      aluX,
	output rvExecPkg::dataT      aluY,
	input  rvExecPkg::dataT      aluO,
	output logic                 writeEnable,
	output rvExecPkg::regNumT    writeNum,
	output rvExecPkg::dataT      writeData,
	output logic                 commitValid,
	output rvExecPkg::commitT    commit,
	output logic                 pcWriteEnable,
	output rvExecPkg::dataT      pcWriteData,
	output logic                 illegal
);

	logic            writesReg;
	logic            redirect;
	rvExecPkg::dataT redirectTarget;
	rvExecPkg::dataT linkData;

	assign aluOp = op.aluOp;
	assign aluX  = op.aluX;
	assign aluY  = op.aluY;

	assign linkData = op.pc + 32'd4; // return address

	always_comb
	begin
		writesReg      = 1'b0;
		writeData      = aluO;
		redirect       = 1'b0;
		redirectTarget = aluO;
		case (op.wbKind)
			rvExecPkg::WbReg: writesReg = 1'b1;
			rvExecPkg::WbLui:
			begin
				writesReg = 1'b1;
				writeData = op.imm;
			end
			rvExecPkg::WbBranch:
			begin
				redirect       = aluO[0]; // comparison result
				redirectTarget = op.pc + op.imm;
			end
			rvExecPkg::WbJal:
			begin
				writesReg = 1'b1;
				writeData = linkData;
				redirect  = 1'b1;
			end
			rvExecPkg::WbJalr:
			begin
				writesReg      = 1'b1;
				writeData      = linkData;
				redirect       = 1'b1;
				redirectTarget = {aluO[31:1], 1'b0};
			end
			default: writesReg = 1'b0; // illegal does nothing here
		endcase
	end

	assign writeNum    = op.regWriteNum;
	assign writeEnable = opValid && writesReg && (op.regWriteNum != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			commitValid   <= 1'b0;
			commit        <= '0;
			pcWriteEnable <= 1'b0;
			pcWriteData   <= '0;
			illegal       <= 1'b0;
		end
		else
		begin
			commitValid   <= writeEnable;
			commit        <= '{regNum: writeNum, data: writeData};
			pcWriteEnable <= opValid && redirect;
			pcWriteData   <= redirectTarget;
			illegal       <= opValid && (op.wbKind == rvExecPkg::WbIllegal);
		end
	end

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  instrValid,
	input  rvExecPkg::instrT      instr,
	output rvExecPkg::regNumT     readNum0,
	output rvExecPkg::regNumT     readNum1,
	input  rvExecPkg::dataT       readData0,
	input  rvExecPkg::dataT       readData1,
	input  logic                  writeEnable,
	input  rvExecPkg::regNumT     writeNum,
	input  rvExecPkg::dataT       writeData,
	output logic                  opValid,
	output rvExecPkg::decodedOpT  op
);

	rvExecPkg::dataT      srcData0;
	rvExecPkg::dataT      srcData1;
	rvExecPkg::decodedOpT opNext;

	assign readNum0 = instr.regNum0;
	assign readNum1 = instr.regNum1;

	// forward the result that stage 2 is writing this cycle
	assign srcData0 = (writeEnable && (writeNum != '0) && (writeNum == instr.regNum0)) ?
		writeData : readData0;
	assign srcData1 = (writeEnable && (writeNum != '0) && (writeNum == instr.regNum1)) ?
		writeData : readData1;

	always_comb
	begin
		opNext             = '0;
		opNext.aluOp       = rvExecPkg::AluAdd;
		opNext.wbKind      = rvExecPkg::WbIllegal;
		opNext.imm         = instr.imm;
		opNext.pc          = instr.pc;
		opNext.regWriteNum = instr.regWriteNum;

		case (instr.opcode)
			rvExecPkg::OpReg, rvExecPkg::OpImm:
			begin
				case (instr.func3)
					3'd0: opNext.aluOp = (instr.opcode == rvExecPkg::OpReg && instr.func7[5]) ?
						rvExecPkg::AluSub : rvExecPkg::AluAdd;
					3'd1: opNext.aluOp = rvExecPkg::AluSll;
					3'd2: opNext.aluOp = rvExecPkg::AluSlt;
					3'd3: opNext.aluOp = rvExecPkg::AluSltu;
					3'd4: opNext.aluOp = rvExecPkg::AluXor;
					3'd5: opNext.aluOp = ((instr.opcode == rvExecPkg::OpReg) ? instr.func7[5] :
						instr.imm[10]) ? rvExecPkg::AluSra : rvExecPkg::AluSrl; // srl / sra
					3'd6: opNext.aluOp = rvExecPkg::AluOr;
					default: opNext.aluOp = rvExecPkg::AluAnd;
				endcase
				opNext.aluX   = srcData0;
				opNext.aluY   = (instr.opcode == rvExecPkg::OpReg) ? srcData1 : instr.imm;
				opNext.wbKind = rvExecPkg::WbReg;
			end
			rvExecPkg::OpBranch:
			begin
				opNext.aluX   = srcData0;
				opNext.aluY   = srcData1;
				opNext.wbKind = rvExecPkg::WbBranch;
				case (instr.func3)
					3'd0: opNext.aluOp = rvExecPkg::AluEq;   // beq
					3'd1: opNext.aluOp = rvExecPkg::AluNe;   // bne
					3'd4: opNext.aluOp = rvExecPkg::AluSlt;  // blt
					3'd5: opNext.aluOp = rvExecPkg::AluGe;   // bge
					3'd6: opNext.aluOp = rvExecPkg::AluSltu; // bltu
					3'd7: opNext.aluOp = rvExecPkg::AluGeu;  // bgeu
					default: opNext.wbKind = rvExecPkg::WbIllegal; // func3 2 and 3 unused
				endcase
			end
			rvExecPkg::OpJal:
			begin
				opNext.aluX   = instr.pc; // target pc + imm
				opNext.aluY   = instr.imm;
				opNext.wbKind = rvExecPkg::WbJal;
			end
			rvExecPkg::OpJalr:
			begin
				opNext.aluX   = srcData0;
				opNext.aluY   = instr.imm;
				opNext.wbKind = rvExecPkg::WbJalr;
			end
			rvExecPkg::OpLui:   opNext.wbKind = rvExecPkg::WbLui;
			rvExecPkg::OpAuipc:
			begin
				opNext.aluX   = instr.pc;
				opNext.aluY   = instr.imm;
				opNext.wbKind = rvExecPkg::WbReg;
			end
			default: opNext.wbKind = rvExecPkg::WbIllegal; // loads, stores, unknown
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			opValid <= 1'b0;
			op      <= '0;
		end
		else
		begin
			opValid <= instrValid;
			if (instrValid)
			begin
				op <= opNext;
			end
		end
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile
(
	input  logic              clk,
	input  logic              reset,
	input  rvExecPkg::regNumT readNum0,
	input  rvExecPkg::regNumT readNum1,
	output rvExecPkg::dataT   readData0,
	output rvExecPkg::dataT   readData1,
	input  logic              writeEnable,
	input  rvExecPkg::regNumT writeNum,
	input  rvExecPkg::dataT   writeData
);

	rvExecPkg::dataT regs [1:31]; // x0 has no storage

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEnable && (writeNum != '0))
		begin
			regs[writeNum] <= writeData;
		end
	end

	// same-cycle writes are not visible here, decode bypasses them
	assign readData0 = (readNum0 == '0) ? '0 : regs[readNum0];
	assign readData1 = (readNum1 == '0) ? '0 : regs[readNum1];

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
(
	input  rvExecPkg::aluOpT aluOp,
	input  rvExecPkg::dataT  aluX,
	input  rvExecPkg::dataT  aluY,
	output rvExecPkg::dataT  aluO
);

	logic [4:0] shamt;

	assign shamt = aluY[4:0]; // shifts only look at the low five bits

	always_comb
	begin
		aluO = '0;
		case (aluOp)
			rvExecPkg::AluAdd:  aluO = aluX + aluY;
			rvExecPkg::AluSub:  aluO = aluX - aluY;
			rvExecPkg::AluSll:  aluO = aluX << shamt;
			rvExecPkg::AluSrl:  aluO = aluX >> shamt;
			rvExecPkg::AluSra:  aluO = $signed(aluX) >>> shamt;
			rvExecPkg::AluXor:  aluO = aluX ^ aluY;
			rvExecPkg::AluOr:   aluO = aluX | aluY;
			rvExecPkg::AluAnd:  aluO = aluX & aluY;
			// comparisons give a single bit in lane 0
			rvExecPkg::AluSlt:  aluO = {31'b0, $signed(aluX) < $signed(aluY)};
			rvExecPkg::AluSltu: aluO = {31'b0, aluX < aluY};
			rvExecPkg::AluEq:   aluO = {31'b0, aluX == aluY};
			rvExecPkg::AluNe:   aluO = {31'b0, aluX != aluY};
			rvExecPkg::AluGe:   aluO = {31'b0, $signed(aluX) >= $signed(aluY)};
			rvExecPkg::AluGeu:  aluO = {31'b0, aluX >= aluY};
			default:            aluO = '0;
		endcase
	end

endmodule

//--- hw/rvExecPkg.sv
package rvExecPkg;

	localparam int DataWidth   = 32;
	localparam int RegNumWidth = 5;
	localparam int OpcodeWidth = 7;
	localparam int AluOpWidth  = 5;
	localparam int WbKindWidth = 3;

	typedef logic [DataWidth-1:0]   dataT; // data word and address
	typedef logic [RegNumWidth-1:0] regNumT;

	// major opcodes of the supported subset, plus the two rejected memory formats
	typedef enum logic [OpcodeWidth-1:0]
	{
		OpReg    = 7'b0110011, // fmt r
		OpImm    = 7'b0010011, // fmt i alu
		OpLoad   = 7'b0000011, // rejected
		OpStore  = 7'b0100011, // rejected
		OpBranch = 7'b1100011,
		OpJal    = 7'b1101111,
		OpJalr   = 7'b1100111,
		OpLui    = 7'b0110111,
		OpAuipc  = 7'b0010111
	} opcodeT;

	typedef enum logic [AluOpWidth-1:0]
	{
		AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor, AluSrl,
		AluSra, AluOr, AluAnd, AluEq, AluNe, AluGe, AluGeu
	} aluOpT;

	// what stage 2 does with the decoded operation
	typedef enum logic [WbKindWidth-1:0]
	{
		WbReg, WbLui, WbBranch, WbJal, WbJalr, WbIllegal
	} wbKindT;

	typedef struct packed
	{
		opcodeT     opcode;
		logic [2:0] func3;
		logic [6:0] func7;
		regNumT     regNum0;
		regNumT     regNum1;
		regNumT     regWriteNum;
		dataT       imm; // already sign extended
		dataT       pc;
	} instrT;

	typedef struct packed
	{
		aluOpT  aluOp;
		wbKindT wbKind;
		dataT   aluX;
		dataT   aluY;
		dataT   imm;
		dataT   pc;
		regNumT regWriteNum;
	} decodedOpT;

	typedef struct packed
	{
		regNumT regNum;
		dataT   data;
	} commitT;

endpackage
